// ==== hw/mod_params_pkg.sv ====
package mod_params_pkg;

  // Segments with independent settings.
  localparam int num_segment = 2;

  // System time is coarsened by this shift before dividing.
  localparam int time_shift = 8;

  // Dividend and quotient width of each divider.
  localparam int div_width = 48;

  // Input register plus one stage per quotient bit.
  localparam int div_latency = div_width + 1;

  // Settling time after a settings change.
  // Latch, two dividers, index register and one spare cycle.
  localparam int total_latency = 1 + 2 * div_latency + 2;

  // Samples per segment.
  localparam int table_depth = 256;
  localparam int table_addr_width = $clog2(table_depth);

endpackage

// ==== hw/mod_types_pkg.sv ====
package mod_types_pkg;
  import mod_params_pkg::*;

  // Free-running system time.
  typedef logic [60:0] sys_time_t;

  // Frequency divider, also used for cycle + 1.
  typedef logic [15:0] freq_div_t;

  // Cycle setting, equal to the last index of a period.
  typedef logic [14:0] cycle_t;

  typedef logic [14:0] idx_t;

  // Modulation amplitude.
  typedef logic [7:0] sample_t;

  typedef logic [$clog2(num_segment)-1:0] seg_t;

  typedef enum logic {
    IDLE,
    LOAD
  } loader_state_t;

endpackage

// ==== hw/mod_settings_loader.sv ====
`timescale 1ns/1ps
module mod_settings_loader
  import mod_params_pkg::*, mod_types_pkg::*;
(
  input  logic      CLK,
  input  logic      rst,
  input  logic      update_settings_in,
  input  cycle_t    cycle [num_segment],
  input  freq_div_t freq_div [num_segment],
  input  seg_t      seg_sel,
  output freq_div_t cycle_len [num_segment],
  output freq_div_t div_value [num_segment],
  output seg_t      req_seg,
  output logic      update_settings_out
);

  loader_state_t state;
  logic [$clog2(total_latency + 1)-1:0] cnt;

  // Divisors start at 1 so the dividers never see zero.
  always_ff @(posedge CLK) begin
    if (rst) begin
      for (int i = 0; i < num_segment; i++) begin
        div_value[i] <= freq_div_t'(1);
        cycle_len[i] <= freq_div_t'(1);
      end
      req_seg <= '0;
    end else if (state == IDLE && update_settings_in) begin
      for (int i = 0; i < num_segment; i++) begin
        div_value[i] <= freq_div[i];
        cycle_len[i] <= {1'b0, cycle[i]} + 1'b1;
      end
      req_seg <= seg_sel;
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      state <= IDLE;
      cnt <= '0;
      update_settings_out <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          update_settings_out <= 1'b0;
          cnt <= '0;
          if (update_settings_in) state <= LOAD;
        end
        LOAD: begin
          cnt <= cnt + 1'b1;
          // Old settings have left the pipeline.
          if (cnt == total_latency) begin
            update_settings_out <= 1'b1;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  a_single_pulse: assert property (@(posedge CLK) disable iff (rst)
    update_settings_out |=> !update_settings_out);

endmodule

// ==== hw/pipe_divider.sv ====
`timescale 1ns/1ps
module pipe_divider #(
  parameter int div_width = 48,
  parameter int divisor_width = 16
) (
  input  logic                     CLK,
  input  logic                     rst,
  input  logic [div_width-1:0]     dividend,
  input  logic [divisor_width-1:0] divisor,
  input  logic                     in_valid,
  output logic [div_width-1:0]     quotient,
  output logic [divisor_width-1:0] remainder,
  output logic                     out_valid
);

  // Stage 0 is the input register, stage j holds j quotient bits.
  logic [div_width-1:0]     num_q [div_width+1];
  logic [divisor_width-1:0] rem_q [div_width+1];
  logic [divisor_width-1:0] den_q [div_width+1];
  logic [div_width:0]       vld_q;

  logic [divisor_width:0] trial [div_width];
  logic [divisor_width:0] diff [div_width];
  logic [div_width-1:0]   take;

  // One restoring step per stage.
  always_comb begin
    for (int j = 0; j < div_width; j++) begin
      trial[j] = {rem_q[j], num_q[j][div_width-1]};
      diff[j] = trial[j] - {1'b0, den_q[j]};
      take[j] = trial[j] >= {1'b0, den_q[j]};
    end
  end

  // Divisor travels with its operand.
  always_ff @(posedge CLK) begin
    num_q[0] <= dividend;
    rem_q[0] <= '0;
    den_q[0] <= divisor;
    for (int j = 0; j < div_width; j++) begin
      num_q[j+1] <= {num_q[j][div_width-2:0], take[j]};
      rem_q[j+1] <= take[j] ? diff[j][divisor_width-1:0] : trial[j][divisor_width-1:0];
      den_q[j+1] <= den_q[j];
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[div_width-1:0], in_valid};
    end
  end

  assign quotient = num_q[div_width];
  assign remainder = rem_q[div_width];
  assign out_valid = vld_q[div_width];

  a_nonzero_divisor: assert property (@(posedge CLK) disable iff (rst)
    in_valid |-> divisor != '0);

endmodule

// ==== hw/modulation_timer.sv ====
`timescale 1ns/1ps
module modulation_timer
  import mod_params_pkg::*, mod_types_pkg::*;
(
  input  logic      CLK,
  input  logic      rst,
  input  sys_time_t sys_time,
  input  freq_div_t div_value [num_segment],
  input  freq_div_t cycle_len [num_segment],
  output idx_t      idx [num_segment],
  output logic      idx_valid [num_segment]
);

  for (genvar i = 0; i < num_segment; i++) begin : gen_seg
    logic [div_width-1:0] quo;
    logic                 quo_valid;
    freq_div_t            rem;
    logic                 rem_valid;
    idx_t                 idx_q;
    logic                 idx_valid_q;

    // Periods of the divided clock.
    pipe_divider #(
      .div_width(div_width),
      .divisor_width($bits(freq_div_t))
    ) div_cnt (
      .CLK,
      .rst,
      .dividend(sys_time[time_shift +: div_width]),
      .divisor(div_value[i]),
      .in_valid(1'b1),
      .quotient(quo),
      .remainder(),
      .out_valid(quo_valid)
    );

    // Position within the modulation cycle.
    pipe_divider #(
      .div_width(div_width),
      .divisor_width($bits(freq_div_t))
    ) div_idx (
      .CLK,
      .rst,
      .dividend(quo),
      .divisor(cycle_len[i]),
      .in_valid(quo_valid),
      .quotient(),
      .remainder(rem),
      .out_valid(rem_valid)
    );

    always_ff @(posedge CLK) begin
      if (rem_valid) idx_q <= rem[$bits(idx_t)-1:0];
    end

    always_ff @(posedge CLK) begin
      if (rst) idx_valid_q <= 1'b0;
      else idx_valid_q <= rem_valid;
    end

    assign idx[i] = idx_q;
    assign idx_valid[i] = idx_valid_q;
  end

endmodule

// ==== hw/mod_sample_table.sv ====
`timescale 1ns/1ps
module mod_sample_table
  import mod_params_pkg::*, mod_types_pkg::*;
(
  input  logic                        CLK,
  input  logic                        rst,
  input  logic                        wr_en,
  input  seg_t                        wr_seg,
  input  logic [table_addr_width-1:0] wr_addr,
  input  sample_t                     wr_data,
  input  idx_t                        idx [num_segment],
  input  logic                        idx_valid [num_segment],
  input  seg_t                        req_seg,
  input  logic                        update_settings,
  output seg_t                        active_seg,
  output sample_t                     sample,
  output logic                        sample_valid
);

  sample_t rd_word [num_segment];

  for (genvar i = 0; i < num_segment; i++) begin : gen_mem
    sample_t mem [table_depth];

    always_ff @(posedge CLK) begin
      if (wr_en && wr_seg == seg_t'(i)) mem[wr_addr] <= wr_data;
    end

    // Index sits below the cycle setting, so the low bits address it.
    assign rd_word[i] = mem[idx[i][table_addr_width-1:0]];

    a_idx_in_table: assert property (@(posedge CLK) disable iff (rst)
      idx_valid[i] |-> idx[i] < table_depth);
  end

  // Swap only once the new settings have drained through.
  always_ff @(posedge CLK) begin
    if (rst) begin
      active_seg <= '0;
      sample_valid <= 1'b0;
    end else begin
      if (update_settings) active_seg <= req_seg;
      sample_valid <= idx_valid[active_seg];
    end
  end

  always_ff @(posedge CLK) begin
    sample <= rd_word[active_seg];
  end

endmodule

// ==== hw/modulation_top.sv ====
`timescale 1ns/1ps
module modulation_top
  import mod_params_pkg::*, mod_types_pkg::*;
(
  input  logic                        CLK,
  input  logic                        rst,
  input  sys_time_t                   sys_time,
  input  logic                        update_settings_in,
  input  cycle_t                      cycle [num_segment],
  input  freq_div_t                   freq_div [num_segment],
  input  seg_t                        seg_sel,
  input  logic                        wr_en,
  input  seg_t                        wr_seg,
  input  logic [table_addr_width-1:0] wr_addr,
  input  sample_t                     wr_data,
  output idx_t                        idx [num_segment],
  output logic                        idx_valid [num_segment],
  output logic                        update_settings_out,
  output seg_t                        active_seg,
  output sample_t                     sample,
  output logic                        sample_valid
);

  freq_div_t cycle_len [num_segment];
  freq_div_t div_value [num_segment];
  seg_t      req_seg;

  mod_settings_loader loader_i (
    .CLK,
    .rst,
    .update_settings_in,
    .cycle,
    .freq_div,
    .seg_sel,
    .cycle_len,
    .div_value,
    .req_seg,
    .update_settings_out
  );

  modulation_timer timer_i (
    .CLK,
    .rst,
    .sys_time,
    .div_value,
    .cycle_len,
    .idx,
    .idx_valid
  );

  mod_sample_table table_i (
    .CLK,
    .rst,
    .wr_en,
    .wr_seg,
    .wr_addr,
    .wr_data,
    .idx,
    .idx_valid,
    .req_seg,
    .update_settings(update_settings_out),
    .active_seg,
    .sample,
    .sample_valid
  );

endmodule

// ==== bench/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic report_failure(input string what);
  $display("%s", what);
  $display("RESULT: FAIL");
  $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_idx(input string name, input idx_t exp, input idx_t act);
  if (act !== exp) begin
    $display("CHECK FAILED t=%0t %s expected %0d actual %0d", $time, name, exp, act);
    report_failure("index mismatch");
  end
endtask

task automatic check_sample(input string name, input sample_t exp, input sample_t act);
  if (act !== exp) begin
    $display("CHECK FAILED t=%0t %s expected %0h actual %0h", $time, name, exp, act);
    report_failure("sample mismatch");
  end
endtask

task automatic check_seg(input string name, input seg_t exp, input seg_t act);
  if (act !== exp) begin
    $display("CHECK FAILED t=%0t %s expected %0d actual %0d", $time, name, exp, act);
    report_failure("segment mismatch");
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("CHECK FAILED t=%0t %s expected %b actual %b", $time, name, exp, act);
    report_failure("control bit mismatch");
  end
endtask

// Polls the updated strobe while random table writes continue.
task automatic wait_pulse(input int limit);
  int k;
  logic seen;
  seen = 1'b0;
  for (k = 0; k < limit && !seen; k++) begin
    step_random();
    if (update_settings_out) seen = 1'b1;
  end
  if (!seen) report_failure("timed out waiting for update_settings_out");
endtask

task automatic wait_idx_valid(input int limit);
  int k;
  logic seen;
  seen = 1'b0;
  for (k = 0; k < limit && !seen; k++) begin
    tick();
    if (idx_valid[0]) seen = 1'b1;
  end
  if (!seen) report_failure("timed out waiting for idx_valid after reset");
endtask

`endif

// ==== bench/tb_modulation.sv ====
`timescale 1ns/1ps
module tb_modulation
  import mod_params_pkg::*, mod_types_pkg::*;
();

  logic CLK = 1'b0;
  logic rst;
  sys_time_t sys_time;
  logic update_settings_in;
  cycle_t cycle [num_segment];
  freq_div_t freq_div [num_segment];
  seg_t seg_sel;
  logic wr_en;
  seg_t wr_seg;
  logic [table_addr_width-1:0] wr_addr;
  sample_t wr_data;
  idx_t idx [num_segment];
  logic idx_valid [num_segment];
  logic update_settings_out;
  seg_t active_seg;
  sample_t sample;
  logic sample_valid;

  logic [31:0] lfsr = 32'hbce3;

  // Reference model state.
  int n = 0;
  int since_rst = 0;
  int busy_until = -1;
  int pulse_at = -1;
  freq_div_t model_div [num_segment];
  freq_div_t model_len [num_segment];
  seg_t model_req;
  seg_t model_active;
  logic exp_sv = 1'b0;
  sample_t exp_sample;
  sample_t mirror [num_segment][table_depth];
  sys_time_t hist_time [$];
  logic [num_segment*32-1:0] hist_set [$];

  always #2 CLK = ~CLK;

  modulation_top dut_i (.*);

  `include "tb_checks.svh"

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit.
  function automatic logic [31:0] draw(input int nbits);
    logic [31:0] val;
    logic fb;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  task automatic tick();
    @(posedge CLK);
    sys_time <= sys_time + sys_time_t'(draw(10)) + 1'b1;
    wr_en <= 1'b0;
    update_settings_in <= 1'b0;
  endtask

  task automatic step_random();
    tick();
    if (draw(3) == 0) begin
      wr_en <= 1'b1;
      wr_seg <= seg_t'(draw(1));
      wr_addr <= table_addr_width'(draw(8));
      wr_data <= sample_t'(draw(8));
    end
  endtask

  task automatic strobe_random();
    tick();
    update_settings_in <= 1'b1;
    seg_sel <= seg_t'(draw(1));
    for (int s = 0; s < num_segment; s++) begin
      freq_div[s] <= freq_div_t'(draw(3)) + 1'b1;
      cycle[s] <= cycle_t'(draw(8));
    end
  endtask

  always @(posedge CLK) begin
    logic [num_segment*32-1:0] set_word;
    sys_time_t t;
    sys_time_t q;
    freq_div_t d;
    freq_div_t l;
    logic exp_valid;
    n++;
    set_word = '0;
    for (int s = 0; s < num_segment; s++) begin
      set_word[s*32 +: 16] = model_div[s];
      set_word[s*32+16 +: 16] = model_len[s];
    end
    hist_time.push_back(sys_time);
    hist_set.push_back(set_word);
    if (hist_time.size() > 100) begin
      void'(hist_time.pop_front());
      void'(hist_set.pop_front());
    end
    // First index leaves the pipeline two dividers and a register after reset.
    exp_valid = !rst && since_rst >= 2 * div_latency + 1;
    if (n >= 2) begin
      for (int s = 0; s < num_segment; s++) begin
        check_bit("idx_valid", exp_valid, idx_valid[s]);
      end
      if (rst) begin
        check_bit("update_settings_out", 1'b0, update_settings_out);
        check_bit("sample_valid", 1'b0, sample_valid);
      end else begin
        check_bit("update_settings_out", n == pulse_at, update_settings_out);
        check_seg("active_seg", model_active, active_seg);
        for (int s = 0; s < num_segment; s++) begin
          if (exp_valid) begin
            // Divider one saw the time at n-99, divider two the cycle at n-50.
            t = hist_time[0];
            d = hist_set[0][s*32 +: 16];
            l = hist_set[49][s*32+16 +: 16];
            q = (t >> time_shift) / sys_time_t'(d);
            check_idx("idx", idx_t'(q % sys_time_t'(l)), idx[s]);
          end
        end
        check_bit("sample_valid", exp_sv, sample_valid);
        if (exp_sv) check_sample("sample", exp_sample, sample);
      end
    end
    exp_sv = exp_valid;
    if (exp_sv) exp_sample = mirror[model_active][idx[model_active][table_addr_width-1:0]];
    if (rst) begin
      since_rst = 0;
      busy_until = -1;
      pulse_at = -1;
      model_active = '0;
      model_req = '0;
      for (int s = 0; s < num_segment; s++) begin
        model_div[s] = 16'd1;
        model_len[s] = 16'd1;
      end
    end else begin
      since_rst++;
      if (n == pulse_at) model_active = model_req;
      if (update_settings_in && n > busy_until) begin
        for (int s = 0; s < num_segment; s++) begin
          model_div[s] = freq_div[s];
          model_len[s] = {1'b0, cycle[s]} + 1'b1;
        end
        model_req = seg_sel;
        busy_until = n + 102;
        pulse_at = n + 103;
      end
    end
    if (wr_en) mirror[wr_seg][wr_addr] = wr_data;
  end

  initial begin
    rst = 1'b1;
    sys_time = sys_time_t'(draw(32));
    update_settings_in = 1'b0;
    seg_sel = '0;
    wr_en = 1'b0;
    wr_seg = '0;
    wr_addr = '0;
    wr_data = '0;
    for (int s = 0; s < num_segment; s++) begin
      cycle[s] = '0;
      freq_div[s] = 16'd1;
    end
    repeat (16) tick();
    rst <= 1'b0;
    // Fill both tables before any sample is checked.
    for (int s = 0; s < num_segment; s++) begin
      for (int a = 0; a < table_depth; a++) begin
        tick();
        wr_en <= 1'b1;
        wr_seg <= seg_t'(s);
        wr_addr <= a[table_addr_width-1:0];
        wr_data <= sample_t'(draw(8));
      end
    end
    wait_idx_valid(300);
    for (int r = 0; r < 6; r++) begin
      strobe_random();
      repeat (5 + draw(5)) step_random();
      // Ignored while the loader is busy.
      strobe_random();
      wait_pulse(200);
      repeat (100 + draw(8)) step_random();
    end
    repeat (200) step_random();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== tb.f ====
hw/mod_params_pkg.sv
hw/mod_types_pkg.sv
hw/mod_settings_loader.sv
hw/pipe_divider.sv
hw/modulation_timer.sv
hw/mod_sample_table.sv
hw/modulation_top.sv
+incdir+bench
bench/tb_modulation.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the modulation testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_modulation -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_modulation > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "RESULT: FAIL" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

exit 0
